// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_vtp_svc
FILELIST = project.f
LOG = sim.log
PASS_MSG = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: project.f
+incdir+.
vtp_pkg.sv
vtp_if.sv
vtp_fifo.sv
vtp_req_arb.sv
vtp_tlb.sv
vtp_lookup_ctrl.sv
vtp_pt_walk.sv
vtp_svc.sv
tb_vtp_svc.sv

// File: tb_vtp_svc.sv
/*
 * Testbench for the VTP translation service: random clients, an in-order
 * walker model and a scoreboard of outstanding tags per port.
 * Run through the Makefile; the last line printed gives the verdict.
 */
`timescale 1ns/100ps
`include "vtp_cfg.svh"

module tb_vtp_svc;
    import vtp_pkg::*;

    localparam int N = `VTP_N_PORTS;
    localparam int STARVE_LIMIT = 200;

    // Accepted request still waiting for its response
    typedef struct packed
    {
        t_port_idx port;
        t_req_tag tag;
        t_page_va va;
    } t_pending;

    // Walker request with the cycle its answer is due
    typedef struct packed
    {
        int due;
        t_port_idx port;
        t_req_tag tag;
        t_page_va va;
    } t_walk_entry;

    logic clk;
    logic reset;
    logic [N-1:0] req_en;
    t_page_va [N-1:0] req_va;
    t_req_tag [N-1:0] req_tag;
    logic [N-1:0] req_rdy;
    logic [N-1:0] rsp_valid;
    t_page_pa rsp_pa;
    t_req_tag rsp_tag;
    logic walk_req_en;
    t_page_va walk_req_va;
    t_port_idx walk_req_port;
    t_req_tag walk_req_tag;
    logic walk_rdy;
    logic walk_rsp_en;
    t_page_va walk_rsp_va;
    t_page_pa walk_rsp_pa;
    t_port_idx walk_rsp_port;
    t_req_tag walk_rsp_tag;

    integer seed;
    int cycle = 0;
    int mismatches;
    int other_errs;
    int walk_req_count;
    logic walk_req_prev;
    int last_walk_due;
    t_pending pend_q[$];
    t_walk_entry walk_q[$];
    t_req_tag next_tag [N];
    int rsp_count [N];
    int last_rsp_cycle [N];
    logic [N-1:0] starve_seen;

    // Stimulus controls
    logic [N-1:0] send_en;
    logic distinct_va;
    t_page_va next_va;
    int walk_rdy_mode;
    logic starve_check;
    logic one_shot_valid;
    int one_shot_port;
    t_page_va one_shot_va;

    vtp_svc UUT
    (
        .clk,
        .reset,
        .req_en,
        .req_va,
        .req_tag,
        .req_rdy,
        .rsp_valid,
        .rsp_pa,
        .rsp_tag,
        .walk_req_en,
        .walk_req_va,
        .walk_req_port,
        .walk_req_tag,
        .walk_rdy,
        .walk_rsp_en,
        .walk_rsp_va,
        .walk_rsp_pa,
        .walk_rsp_port,
        .walk_rsp_tag
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // ====================
    // Models and checks
    // ====================

    // Page table contents, fixed for the whole run
    function automatic t_page_pa map_page(input t_page_va va);
        return va ^ 20'h5a5a5;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            mismatches++;
            $display("Mismatch: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic int find_pending(input int p, input t_req_tag tag);
        int i;
        find_pending = -1;
        for (i = 0; i < pend_q.size(); i++)
            if (find_pending < 0 && int'(pend_q[i].port) == p && pend_q[i].tag == tag)
                find_pending = i;
    endfunction

    function automatic int count_pending(input int p);
        int i;
        count_pending = 0;
        for (i = 0; i < pend_q.size(); i++)
            if (int'(pend_q[i].port) == p)
                count_pending++;
    endfunction

    // Walker model queues the request, answers come back in order
    task automatic record_walk_req();
        t_walk_entry entry;
        if (walk_req_prev)
        begin
            other_errs++;
            $display("Walker requests issued on two consecutive cycles");
        end
        entry.due = cycle + 2 + int'($unsigned($random(seed)) % 8);
        if (entry.due <= last_walk_due)
            entry.due = last_walk_due + 1;
        last_walk_due = entry.due;
        entry.port = walk_req_port;
        entry.tag = walk_req_tag;
        entry.va = walk_req_va;
        walk_q.push_back(entry);
        walk_req_count++;
    endtask

    // Scoreboard match, any outstanding tag on the port may answer
    task automatic check_response();
        int i;
        int p;
        int idx;
        p = 0;
        check_value("rsp_valid_onehot", 32'd1, 32'($countones(rsp_valid)));
        for (i = 0; i < N; i++)
            if (rsp_valid[i])
                p = i;
        idx = find_pending(p, rsp_tag);
        if (idx < 0)
        begin
            other_errs++;
            $display("Response on port %0d with tag %h that was never requested", p, rsp_tag);
        end
        else
        begin
            check_value("rsp_pa", 32'(map_page(pend_q[idx].va)), 32'(rsp_pa));
            pend_q.delete(idx);
            rsp_count[p]++;
            last_rsp_cycle[p] = cycle;
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (walk_req_en)
                record_walk_req();
            walk_req_prev = walk_req_en;
            if (rsp_valid != '0)
                check_response();
        end
    end

    // ====================
    // Stimulus
    // ====================

    task automatic send_request(input int p, input t_page_va va);
        t_pending entry;
        entry.port = t_port_idx'(p);
        entry.tag = next_tag[p];
        entry.va = va;
        pend_q.push_back(entry);
        req_en[p] = 1'b1;
        req_va[p] = va;
        req_tag[p] = next_tag[p];
        next_tag[p] = next_tag[p] + 1'b1;
    endtask

    task automatic check_starvation();
        int p;
        for (p = 0; p < N; p++)
        begin
            if (!starve_seen[p] && count_pending(p) > 0 &&
                (cycle - last_rsp_cycle[p]) > STARVE_LIMIT)
            begin
                starve_seen[p] = 1'b1;
                other_errs++;
                $display("Port %0d got no response for %0d cycles", p, STARVE_LIMIT);
            end
        end
    endtask

    // One clock of walker and client activity, inputs change after the edge
    task automatic drive_cycle();
        int p;
        t_page_va va;
        @(posedge clk);
        #2;
        case (walk_rdy_mode)
            0: if (($random(seed) & 3) == 0) walk_rdy = !walk_rdy;
            1: walk_rdy = 1'b0;
            default: walk_rdy = 1'b1;
        endcase
        walk_rsp_en = 1'b0;
        if (walk_q.size() > 0 && cycle >= walk_q[0].due)
        begin
            walk_rsp_en = 1'b1;
            walk_rsp_va = walk_q[0].va;
            walk_rsp_pa = map_page(walk_q[0].va);
            walk_rsp_port = walk_q[0].port;
            walk_rsp_tag = walk_q[0].tag;
            void'(walk_q.pop_front());
        end
        for (p = 0; p < N; p++)
        begin
            req_en[p] = 1'b0;
            if (req_rdy[p] && one_shot_valid && one_shot_port == p)
            begin
                send_request(p, one_shot_va);
                one_shot_valid = 1'b0;
            end
            else if (req_rdy[p] && send_en[p] && (($random(seed) & 3) != 0))
            begin
                // Small pool of pages gives a mix of hits and misses
                if (distinct_va)
                begin
                    va = next_va;
                    next_va = next_va + 1'b1;
                end
                else
                    va = t_page_va'($random(seed)) & 20'h0003f;
                send_request(p, va);
            end
        end
        if (starve_check)
            check_starvation();
    endtask

    task automatic send_single(input int p, input t_page_va va);
        int n;
        one_shot_port = p;
        one_shot_va = va;
        one_shot_valid = 1'b1;
        n = 0;
        while (one_shot_valid && n < 100)
        begin
            drive_cycle();
            n++;
        end
        if (one_shot_valid)
        begin
            one_shot_valid = 1'b0;
            other_errs++;
            $display("Port %0d never became ready for a single request", p);
        end
    endtask

    task automatic wait_all_done(input string name, input int limit);
        int n;
        n = 0;
        while (pend_q.size() > 0 && n < limit)
        begin
            drive_cycle();
            n++;
        end
        if (pend_q.size() > 0)
        begin
            other_errs++;
            $display("Timeout in %s with %0d requests outstanding", name, pend_q.size());
        end
    endtask

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        int i;
        int p;
        int n;
        int base_walks;
        int base_count [N];

        seed = 32'hb4ab_ec22;
        clk = 1'b0;
        reset = 1'b1;
        req_en = '0;
        req_va = '0;
        req_tag = '0;
        walk_rdy = 1'b0;
        walk_rsp_en = 1'b0;
        walk_rsp_va = '0;
        walk_rsp_pa = '0;
        walk_rsp_port = '0;
        walk_rsp_tag = '0;
        mismatches = 0;
        other_errs = 0;
        walk_req_count = 0;
        walk_req_prev = 1'b0;
        last_walk_due = 0;
        send_en = '0;
        distinct_va = 1'b0;
        next_va = 20'h40000;
        walk_rdy_mode = 0;
        starve_check = 1'b0;
        starve_seen = '0;
        one_shot_valid = 1'b0;
        one_shot_port = 0;
        one_shot_va = '0;
        for (p = 0; p < N; p++)
        begin
            next_tag[p] = '0;
            rsp_count[p] = 0;
            last_rsp_cycle[p] = 0;
        end

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // Quiet outputs and open inputs before any traffic
        for (i = 0; i < 10; i++)
        begin
            drive_cycle();
            check_value("idle_rsp_valid", 32'd0, 32'(rsp_valid));
            check_value("idle_walk_req_en", 32'd0, 32'(walk_req_en));
            check_value("idle_req_rdy", 32'((1 << N) - 1), 32'(req_rdy));
        end

        // First access walks, the repeat must hit
        base_walks = walk_req_count;
        send_single(0, 20'h71234);
        wait_all_done("first lookup", 300);
        check_value("first_lookup_walks", 32'(base_walks + 1), 32'(walk_req_count));
        repeat (5) drive_cycle();
        base_walks = walk_req_count;
        send_single(0, 20'h71234);
        wait_all_done("repeat lookup", 300);
        check_value("repeat_lookup_walks", 32'(base_walks), 32'(walk_req_count));

        // Stalled walker backs up into the client FIFOs
        walk_rdy_mode = 1;
        distinct_va = 1'b1;
        send_en = 4'b0110;
        base_count[1] = rsp_count[1];
        base_count[2] = rsp_count[2];
        n = 0;
        while ((req_rdy[1] || req_rdy[2]) && n < 300)
        begin
            drive_cycle();
            n++;
        end
        if (req_rdy[1] || req_rdy[2])
        begin
            other_errs++;
            $display("req_rdy stayed high on ports 1 and 2 with the walker stalled");
        end
        repeat (20) drive_cycle();
        check_value("stalled_rsp_port1", 32'(base_count[1]), 32'(rsp_count[1]));
        check_value("stalled_rsp_port2", 32'(base_count[2]), 32'(rsp_count[2]));
        send_en = '0;
        walk_rdy_mode = 0;
        wait_all_done("walker release", 2000);

        // All ports busy, each must keep making progress
        distinct_va = 1'b0;
        send_en = '1;
        for (p = 0; p < N; p++)
        begin
            base_count[p] = rsp_count[p];
            last_rsp_cycle[p] = cycle;
        end
        starve_check = 1'b1;
        repeat (600) drive_cycle();
        starve_check = 1'b0;
        send_en = '0;
        wait_all_done("continuous traffic", 3000);
        for (p = 0; p < N; p++)
        begin
            if (rsp_count[p] == base_count[p])
            begin
                other_errs++;
                $display("Port %0d received no responses under full load", p);
            end
        end

        repeat (20) drive_cycle();
        if (pend_q.size() != 0)
        begin
            other_errs++;
            $display("%0d requests left without a response", pend_q.size());
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: vtp_cfg.svh
/*
 * Build-time constants for the VTP page translation service.
 * Include wherever logic is sized by port count, page width or queue depth.
 */
`ifndef VTP_CFG_SVH
`define VTP_CFG_SVH

// Clients sharing the one translation pipeline
`define VTP_N_PORTS 4

// 4 KB page numbers, same width for VA and PA
`define VTP_PAGE_BITS 20

// Client tag, returned unchanged with the translation
`define VTP_TAG_BITS 8

// Per-client request buffering
`define VTP_IN_FIFO_DEPTH 4

// Direct-mapped TLB geometry and lookup latency
`define VTP_TLB_SETS 16
`define VTP_TLB_PIPE_STAGES 2

// Misses waiting for the external walker
`define VTP_WALK_FIFO_DEPTH 8

`endif

// File: vtp_fifo.sv
/*
 * Circular-buffer FIFO with a registered head entry.
 * almost_full rises once free entries drop to THRESHOLD.
 */
`timescale 1ns/100ps

module vtp_fifo
#(
    parameter int N_DATA_BITS = 8,
    parameter int N_ENTRIES = 4,
    parameter int THRESHOLD = 1
)
(
    input  logic clk,
    input  logic reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,
    output logic almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    localparam int PTR_BITS = $clog2(N_ENTRIES);
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] rd_ptr_next;
    logic [CNT_BITS-1:0] count;

    // Pointer increment, wraps at any depth
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rd_ptr_next = deq_en ? ptr_inc(rd_ptr) : rd_ptr;

    // Flags from the occupancy register
    assign not_empty = (count != '0);
    assign not_full = (int'(count) < N_ENTRIES);
    assign almost_full = ((N_ENTRIES - int'(count)) <= THRESHOLD);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= ptr_inc(wr_ptr);
            rd_ptr <= rd_ptr_next;
            count <= count + CNT_BITS'(enq_en) - CNT_BITS'(deq_en);
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    // Head register, bypass when the new head is being written now
    always_ff @(posedge clk)
    begin
        if (enq_en && (wr_ptr == rd_ptr_next))
            first <= enq_data;
        else
            first <= mem[rd_ptr_next];
    end

    a_no_enq_full: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> not_full);

    a_no_deq_empty: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty);

endmodule

// File: vtp_if.sv
/*
 * Internal buses of the VTP service: merged request stream, TLB
 * lookup and fill, and the miss path to the page walk stage.
 */
`timescale 1ns/100ps

// Arbitrated request stream, one entry leaves per deq
interface vtp_req_stream_if;
    import vtp_pkg::*;

    logic valid;
    t_lookup_req req;
    t_port_idx port;
    logic deq;

    modport source (output valid, output req, output port, input deq);
    modport sink (input valid, input req, input port, output deq);
endinterface

// TLB lookup pipeline plus fill port
interface vtp_tlb_if;
    import vtp_pkg::*;

    logic lookup_en;
    t_page_va lookup_va;
    logic lookup_rdy;
    logic rsp_hit;
    logic rsp_miss;
    t_page_pa rsp_pa;

    logic fill_en;
    t_page_va fill_va;
    t_page_pa fill_pa;

    modport lookup (output lookup_en, output lookup_va,
                    input lookup_rdy, input rsp_hit, input rsp_miss, input rsp_pa);
    modport fill (output fill_en, output fill_va, output fill_pa);
    modport server (input lookup_en, input lookup_va,
                    output lookup_rdy, output rsp_hit, output rsp_miss, output rsp_pa,
                    input fill_en, input fill_va, input fill_pa);
endinterface

// Misses out to the walk stage, walker answers back
interface vtp_miss_if;
    import vtp_pkg::*;

    logic walk_valid;
    t_lookup_req walk_req;
    t_port_idx walk_port;
    logic walk_not_full;

    logic rsp_valid;
    t_lookup_rsp rsp;
    t_port_idx rsp_port;

    modport ctrl (output walk_valid, output walk_req, output walk_port,
                  input walk_not_full, input rsp_valid, input rsp, input rsp_port);
    modport walker (input walk_valid, input walk_req, input walk_port,
                    output walk_not_full, output rsp_valid, output rsp, output rsp_port);
endinterface

// File: vtp_lookup_ctrl.sv
/*
 * Feeds the merged stream into the TLB, pairs results with their requests,
 * sends misses to the walk stage and returns responses to the clients.
 */
`timescale 1ns/100ps
`include "vtp_cfg.svh"

module vtp_lookup_ctrl
(
    input  logic clk,
    input  logic reset,

    vtp_req_stream_if.sink stream,
    vtp_tlb_if.lookup tlb,
    vtp_miss_if.ctrl miss,

    output logic [`VTP_N_PORTS-1:0] rsp_valid,
    output vtp_pkg::t_page_pa rsp_pa,
    output vtp_pkg::t_req_tag rsp_tag
);
    import vtp_pkg::*;

    // Covers the TLB pipeline plus results waiting on the walk stage
    localparam int INFLIGHT_ENTRIES = `VTP_TLB_PIPE_STAGES + 6;
    localparam int INFLIGHT_THRESHOLD = 2;

    logic inflight_afull;
    logic inflight_ne;
    t_lookup_req proc_req;
    t_port_idx proc_port;

    logic res_valid;
    logic res_hit;
    t_page_pa res_pa;
    logic res_deq;
    logic do_hit_rsp;

    // ====================
    // Issue lookups
    // ====================

    assign tlb.lookup_en = stream.valid && !inflight_afull && tlb.lookup_rdy;
    assign tlb.lookup_va = stream.req.va;
    assign stream.deq = tlb.lookup_en;

    // Requests in flight, in TLB order
    vtp_fifo
    #(
        .N_DATA_BITS($bits(t_lookup_req) + $bits(t_port_idx)),
        .N_ENTRIES(INFLIGHT_ENTRIES),
        .THRESHOLD(INFLIGHT_THRESHOLD)
    )
    inflight_fifo
    (
        .clk,
        .reset,
        .enq_data({stream.req, stream.port}),
        .enq_en(tlb.lookup_en),
        .not_full(),
        .almost_full(inflight_afull),
        .first({proc_req, proc_port}),
        .deq_en(res_deq),
        .not_empty(inflight_ne)
    );

    // TLB results, never more than the in-flight count so no full check
    vtp_fifo
    #(
        .N_DATA_BITS(1 + $bits(t_page_pa)),
        .N_ENTRIES(INFLIGHT_ENTRIES),
        .THRESHOLD(INFLIGHT_THRESHOLD)
    )
    result_fifo
    (
        .clk,
        .reset,
        .enq_data({tlb.rsp_hit, tlb.rsp_pa}),
        .enq_en(tlb.rsp_hit || tlb.rsp_miss),
        .not_full(),
        .almost_full(),
        .first({res_hit, res_pa}),
        .deq_en(res_deq),
        .not_empty(res_valid)
    );

    // ====================
    // Retire results
    // ====================

    // Walker answers own the response register this cycle
    assign do_hit_rsp = res_valid && res_hit && !miss.rsp_valid;

    // Misses move on only while the walk stage has room
    assign miss.walk_valid = res_valid && !res_hit && miss.walk_not_full;
    assign miss.walk_req = proc_req;
    assign miss.walk_port = proc_port;

    assign res_deq = do_hit_rsp || miss.walk_valid;

    // One-hot port strobe, walk response first
    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= '0;
        else
        begin
            rsp_valid <= '0;
            if (miss.rsp_valid)
                rsp_valid[miss.rsp_port] <= 1'b1;
            else if (do_hit_rsp)
                rsp_valid[proc_port] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (miss.rsp_valid)
        begin
            rsp_pa <= miss.rsp.pa;
            rsp_tag <= miss.rsp.tag;
        end
        else
        begin
            rsp_pa <= res_pa;
            rsp_tag <= proc_req.tag;
        end
    end

    // A TLB answer needs a request that was recorded when it was issued
    a_rsp_has_req: assert property (@(posedge clk) disable iff (reset)
        (tlb.rsp_hit || tlb.rsp_miss) |-> inflight_ne);

endmodule

// File: vtp_pkg.sv
/*
 * Types shared by the VTP service modules and interfaces.
 * Compile before any file that names vtp_pkg.
 */
`include "vtp_cfg.svh"

package vtp_pkg;

    // Page numbers, offset bits stripped
    typedef logic [`VTP_PAGE_BITS-1:0] t_page_va;
    typedef logic [`VTP_PAGE_BITS-1:0] t_page_pa;

    typedef logic [`VTP_TAG_BITS-1:0] t_req_tag;

    // Index of the requesting client
    typedef logic [$clog2(`VTP_N_PORTS)-1:0] t_port_idx;

    // Client request, VA in the upper bits
    typedef struct packed
    {
        t_page_va va;
        t_req_tag tag;
    } t_lookup_req;

    // Translation returned to a client
    typedef struct packed
    {
        t_page_pa pa;
        t_req_tag tag;
    } t_lookup_rsp;

endpackage

// File: vtp_pt_walk.sv
/*
 * Page walk stage: queues TLB misses for the external walker and turns
 * walker answers into client responses and TLB fills.
 */
`timescale 1ns/100ps
`include "vtp_cfg.svh"

module vtp_pt_walk
(
    input  logic clk,
    input  logic reset,

    vtp_miss_if.walker miss,
    vtp_tlb_if.fill fill,

    // External walker, request side
    output logic walk_req_en,
    output vtp_pkg::t_page_va walk_req_va,
    output vtp_pkg::t_port_idx walk_req_port,
    output vtp_pkg::t_req_tag walk_req_tag,
    input  logic walk_rdy,

    // External walker, response side
    input  logic walk_rsp_en,
    input  vtp_pkg::t_page_va walk_rsp_va,
    input  vtp_pkg::t_page_pa walk_rsp_pa,
    input  vtp_pkg::t_port_idx walk_rsp_port,
    input  vtp_pkg::t_req_tag walk_rsp_tag
);
    import vtp_pkg::*;

    logic miss_ne;
    logic miss_deq;
    t_lookup_req miss_first;
    t_port_idx miss_first_port;

    // Lets hits flow past a run of misses
    vtp_fifo
    #(
        .N_DATA_BITS($bits(t_lookup_req) + $bits(t_port_idx)),
        .N_ENTRIES(`VTP_WALK_FIFO_DEPTH),
        .THRESHOLD(1)
    )
    miss_fifo
    (
        .clk,
        .reset,
        .enq_data({miss.walk_req, miss.walk_port}),
        .enq_en(miss.walk_valid),
        .not_full(miss.walk_not_full),
        .almost_full(),
        .first({miss_first, miss_first_port}),
        .deq_en(miss_deq),
        .not_empty(miss_ne)
    );

    // Gap cycle after each request, walker sees walk_rdy first
    assign miss_deq = miss_ne && walk_rdy && !walk_req_en;

    always_ff @(posedge clk)
    begin
        if (reset)
            walk_req_en <= 1'b0;
        else
            walk_req_en <= miss_deq;
    end

    // Port index rides along as walker metadata
    always_ff @(posedge clk)
    begin
        walk_req_va <= miss_first.va;
        walk_req_port <= miss_first_port;
        walk_req_tag <= miss_first.tag;
    end

    // Walker answer becomes a client response and a fill together
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            miss.rsp_valid <= 1'b0;
            fill.fill_en <= 1'b0;
        end
        else
        begin
            miss.rsp_valid <= walk_rsp_en;
            fill.fill_en <= walk_rsp_en;
        end
    end

    always_ff @(posedge clk)
    begin
        miss.rsp.pa <= walk_rsp_pa;
        miss.rsp.tag <= walk_rsp_tag;
        miss.rsp_port <= walk_rsp_port;
        fill.fill_va <= walk_rsp_va;
        fill.fill_pa <= walk_rsp_pa;
    end

    a_rsp_port_range: assert property (@(posedge clk) disable iff (reset)
        walk_rsp_en |-> (int'(walk_rsp_port) < `VTP_N_PORTS));

endmodule

// File: vtp_req_arb.sv
/*
 * Merges the client request FIFOs into one stream.
 * Round-robin grant is registered, the winner lands in a small merged FIFO.
 */
`timescale 1ns/100ps
`include "vtp_cfg.svh"

module vtp_req_arb
(
    input  logic clk,
    input  logic reset,

    input  logic [`VTP_N_PORTS-1:0] req_en,
    input  vtp_pkg::t_page_va [`VTP_N_PORTS-1:0] req_va,
    input  vtp_pkg::t_req_tag [`VTP_N_PORTS-1:0] req_tag,
    output logic [`VTP_N_PORTS-1:0] req_rdy,

    vtp_req_stream_if.source stream
);
    import vtp_pkg::*;

    // Merged FIFO sized for the two-cycle grant to enqueue delay
    localparam int MERGED_ENTRIES = 4;
    localparam int MERGED_THRESHOLD = 2;

    t_lookup_req in_first [`VTP_N_PORTS];
    logic [`VTP_N_PORTS-1:0] in_ne;
    logic [`VTP_N_PORTS-1:0] in_deq;

    logic grant_valid;
    t_port_idx grant_idx;
    logic grant_valid_q;
    t_port_idx grant_idx_q;
    t_port_idx last_idx;

    logic merged_afull;
    logic winner_en;
    t_lookup_req winner_req;
    t_port_idx winner_port;

    // ====================
    // Client input FIFOs
    // ====================

    for (genvar p = 0; p < `VTP_N_PORTS; p++)
    begin : g_in
        vtp_fifo
        #(
            .N_DATA_BITS($bits(t_lookup_req)),
            .N_ENTRIES(`VTP_IN_FIFO_DEPTH),
            .THRESHOLD(1)
        )
        in_fifo
        (
            .clk,
            .reset,
            .enq_data({req_va[p], req_tag[p]}),
            .enq_en(req_en[p]),
            .not_full(req_rdy[p]),
            .almost_full(),
            .first(in_first[p]),
            .deq_en(in_deq[p]),
            .not_empty(in_ne[p])
        );
    end

    // ====================
    // Round-robin arbiter
    // ====================

    // Search starts one past the last winner, which comes last
    always_comb
    begin
        t_port_idx idx;

        grant_valid = 1'b0;
        grant_idx = last_idx;
        for (int i = 1; i <= `VTP_N_PORTS; i++)
        begin
            idx = last_idx + t_port_idx'(i);
            if (!grant_valid && !merged_afull && in_ne[idx])
            begin
                grant_valid = 1'b1;
                grant_idx = idx;
            end
        end
    end

    // Registered grant is a cycle old, so recheck the FIFO still has data
    always_comb
    begin
        in_deq = '0;
        in_deq[grant_idx_q] = grant_valid_q && in_ne[grant_idx_q];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grant_valid_q <= 1'b0;
            last_idx <= '1;
            winner_en <= 1'b0;
        end
        else
        begin
            grant_valid_q <= grant_valid;
            if (grant_valid)
                last_idx <= grant_idx;
            winner_en <= |in_deq;
        end
    end

    // Winner payload and port index
    always_ff @(posedge clk)
    begin
        grant_idx_q <= grant_idx;
        winner_req <= in_first[grant_idx_q];
        winner_port <= grant_idx_q;
    end

    // ====================
    // Merged FIFO
    // ====================

    vtp_fifo
    #(
        .N_DATA_BITS($bits(t_lookup_req) + $bits(t_port_idx)),
        .N_ENTRIES(MERGED_ENTRIES),
        .THRESHOLD(MERGED_THRESHOLD)
    )
    merged_fifo
    (
        .clk,
        .reset,
        .enq_data({winner_req, winner_port}),
        .enq_en(winner_en),
        .not_full(),
        .almost_full(merged_afull),
        .first({stream.req, stream.port}),
        .deq_en(stream.deq),
        .not_empty(stream.valid)
    );

endmodule

// File: vtp_svc.sv
/*
 * Top level of the VTP translation service.
 * Clients and the page table walker connect through plain ports.
 */
`timescale 1ns/100ps
`include "vtp_cfg.svh"

module vtp_svc
(
    input  logic clk,
    input  logic reset,

    // Clients
    input  logic [`VTP_N_PORTS-1:0] req_en,
    input  vtp_pkg::t_page_va [`VTP_N_PORTS-1:0] req_va,
    input  vtp_pkg::t_req_tag [`VTP_N_PORTS-1:0] req_tag,
    output logic [`VTP_N_PORTS-1:0] req_rdy,
    output logic [`VTP_N_PORTS-1:0] rsp_valid,
    output vtp_pkg::t_page_pa rsp_pa,
    output vtp_pkg::t_req_tag rsp_tag,

    // Page table walker
    output logic walk_req_en,
    output vtp_pkg::t_page_va walk_req_va,
    output vtp_pkg::t_port_idx walk_req_port,
    output vtp_pkg::t_req_tag walk_req_tag,
    input  logic walk_rdy,
    input  logic walk_rsp_en,
    input  vtp_pkg::t_page_va walk_rsp_va,
    input  vtp_pkg::t_page_pa walk_rsp_pa,
    input  vtp_pkg::t_port_idx walk_rsp_port,
    input  vtp_pkg::t_req_tag walk_rsp_tag
);

    vtp_req_stream_if stream_if();
    vtp_tlb_if tlb_if();
    vtp_miss_if miss_if();

    // Client FIFOs and arbitration
    vtp_req_arb arb
    (
        .clk,
        .reset,
        .req_en,
        .req_va,
        .req_tag,
        .req_rdy,
        .stream(stream_if.source)
    );

    vtp_tlb tlb
    (
        .clk,
        .reset,
        .tlb(tlb_if.server)
    );

    // Lookup issue and response merge
    vtp_lookup_ctrl ctrl
    (
        .clk,
        .reset,
        .stream(stream_if.sink),
        .tlb(tlb_if.lookup),
        .miss(miss_if.ctrl),
        .rsp_valid,
        .rsp_pa,
        .rsp_tag
    );

    vtp_pt_walk pt_walk
    (
        .clk,
        .reset,
        .miss(miss_if.walker),
        .fill(tlb_if.fill),
        .walk_req_en,
        .walk_req_va,
        .walk_req_port,
        .walk_req_tag,
        .walk_rdy,
        .walk_rsp_en,
        .walk_rsp_va,
        .walk_rsp_pa,
        .walk_rsp_port,
        .walk_rsp_tag
    );

endmodule

// File: vtp_tlb.sv
/*
 * Direct-mapped TLB for 4 KB pages with a fixed two-stage lookup.
 * Fills from the page walk stage overwrite the indexed set.
 */
`timescale 1ns/100ps
`include "vtp_cfg.svh"

module vtp_tlb
(
    input  logic clk,
    input  logic reset,

    vtp_tlb_if.server tlb
);
    import vtp_pkg::*;

    localparam int IDX_BITS = $clog2(`VTP_TLB_SETS);
    localparam int VTAG_BITS = `VTP_PAGE_BITS - IDX_BITS;

    // Per-set valid, VA tag and translation
    logic [`VTP_TLB_SETS-1:0] valid;
    logic [VTAG_BITS-1:0] va_tag [`VTP_TLB_SETS];
    t_page_pa pa [`VTP_TLB_SETS];

    logic [IDX_BITS-1:0] fill_idx;
    logic [IDX_BITS-1:0] s1_idx;
    logic s1_en;
    t_page_va s1_va;
    logic s1_match;

    logic s2_hit;
    logic s2_miss;
    t_page_pa s2_pa;

    // Lookups are always accepted because nothing in the TLB stalls
    assign tlb.lookup_rdy = 1'b1;

    // Set index is the low page VA bits
    assign fill_idx = tlb.fill_va[IDX_BITS-1:0];
    assign s1_idx = s1_va[IDX_BITS-1:0];

    // ====================
    // Fill
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
            valid <= '0;
        else if (tlb.fill_en)
            valid[fill_idx] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (tlb.fill_en)
        begin
            va_tag[fill_idx] <= tlb.fill_va[`VTP_PAGE_BITS-1:IDX_BITS];
            pa[fill_idx] <= tlb.fill_pa;
        end
    end

    // ====================
    // Lookup pipeline
    // ====================

    // A fill written last cycle is already seen by stage 1
    assign s1_match = valid[s1_idx] && (va_tag[s1_idx] == s1_va[`VTP_PAGE_BITS-1:IDX_BITS]);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_en <= 1'b0;
            s2_hit <= 1'b0;
            s2_miss <= 1'b0;
        end
        else
        begin
            s1_en <= tlb.lookup_en;
            s2_hit <= s1_en && s1_match;
            s2_miss <= s1_en && !s1_match;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_va <= tlb.lookup_va;
        s2_pa <= pa[s1_idx];
    end

    assign tlb.rsp_hit = s2_hit;
    assign tlb.rsp_miss = s2_miss;
    assign tlb.rsp_pa = s2_pa;

    a_hit_miss_excl: assert property (@(posedge clk) disable iff (reset)
        !(tlb.rsp_hit && tlb.rsp_miss));

endmodule
